//--- PipelineCore.f
logic/PipeCtrlTypes.sv
logic/PipelineController.sv
logic/FetchStage.sv
logic/DecodeStage.sv
logic/RenameStage.sv
logic/CommitStage.sv
logic/PipelineCore.sv
bench/PipelineCoreTb.sv

//--- Makefile
# Verilator simulation of the pipeline core

VERILATOR ?= verilator
TOP       ?= PipelineCoreTb
FILELIST  ?= PipelineCore.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Done: no errors

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)

//--- bench/PipelineCoreTb.sv
/* pipeline core testbench */
`timescale 1ns/1ps

module PipelineCoreTb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 2;
    localparam int PROGRAM_SIZE = 256;

    localparam int MODE_CLEAN  = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_HOLDS  = 2;

    // one expected retire
    typedef struct packed {
        PipeCtrlTypes::PcAddr pc;
        PipeCtrlTypes::OpKind kind;
        logic                 uopIndex;
    } Expected;

    logic                     clk;
    logic                     rst;
    PipeCtrlTypes::OpWord     fetchWord;
    logic                     fetchHit;
    logic                     irq;
    logic                     fetchEnable;
    logic                     issueHold;
    PipeCtrlTypes::PcAddr     fetchAddr;
    PipeCtrlTypes::RetireInfo retire;
    logic                     pipelineEmpty;

    PipeCtrlTypes::OpWord progMem [PROGRAM_SIZE];
    Expected              expectQ [$];
    PipeCtrlTypes::PcAddr modelPc;
    int                   retireCount;
    int                   mode;
    int                   holdLeft;
    logic                 runEnable;

    PipelineCore dut_i (
        .clk, .rst, .fetchWord, .fetchHit, .irq, .fetchEnable, .issueHold,
        .fetchAddr, .retire, .pipelineEmpty
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // about one word in six is a branch
    task automatic buildProgram();
        PipeCtrlTypes::OpKind kind;
        logic                 mispredict;
        for (int i = 0; i < PROGRAM_SIZE; i++) begin
            mispredict = 1'b0;
            if ($urandom % 6 == 0) begin
                kind       = PipeCtrlTypes::OP_BRANCH;
                mispredict = ($urandom % 3 == 0);
            end else if ($urandom % 4 == 0) begin
                kind = PipeCtrlTypes::OP_DOUBLE;
            end else begin
                kind = PipeCtrlTypes::OP_NORMAL;
            end
            progMem[8'(i)] = {kind, mispredict, 13'($urandom)};
        end
    endtask

    task automatic expectRetire(input PipeCtrlTypes::PcAddr pc,
                                input PipeCtrlTypes::OpKind kind, input logic uopIndex);
        Expected entry;
        entry.pc       = pc;
        entry.kind     = kind;
        entry.uopIndex = uopIndex;
        expectQ.push_back(entry);
    endtask

    // walk one instruction of the architectural path
    task automatic stepModel();
        PipeCtrlTypes::OpWord word;
        PipeCtrlTypes::OpKind kind;
        word = progMem[modelPc];
        kind = word[15:14];
        expectRetire(modelPc, kind, 1'b0);
        if (kind == PipeCtrlTypes::OP_DOUBLE) begin
            expectRetire(modelPc, kind, 1'b1);
        end
        // a mispredicted branch continues at its target
        if (kind == PipeCtrlTypes::OP_BRANCH && word[13]) begin
            modelPc = word[7:0];
        end else begin
            modelPc = modelPc + 8'd1;
        end
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "run aborted");
    endtask

    // outputs settle well before the falling edge
    task automatic sampleCycle();
        Expected want;
        @(negedge clk);
        if (retire.valid) begin
            if (expectQ.size() == 0) begin
                stepModel();
            end
            want = expectQ.pop_front();
            checkValue(32'(retire.pc), 32'(want.pc), "retire pc");
            checkValue(32'(retire.kind), 32'(want.kind), "retire kind");
            checkValue(32'(retire.uopIndex), 32'(want.uopIndex), "retire uopIndex");
            retireCount++;
        end
    endtask

    task automatic waitRetires(input int target, input int limit, input string phase);
        int cycles;
        cycles = 0;
        while (retireCount < target) begin
            if (cycles == limit) begin
                abortRun($sformatf("timeout in %s phase: only %0d retires after %0d cycles",
                    phase, retireCount, cycles));
            end
            sampleCycle();
            cycles++;
        end
    endtask

    // inputs change shortly after the rising edge
    always @(posedge clk) begin
        #DRIVE_DELAY;
        fetchWord   = progMem[fetchAddr];
        fetchEnable = runEnable;
        case (mode)
            MODE_CLEAN: begin
                fetchHit  = 1'b1;
                irq       = 1'b0;
                issueHold = 1'b0;
            end
            MODE_RANDOM: begin
                fetchHit  = ($urandom % 5 != 0);
                irq       = ($urandom % 10 == 0);
                issueHold = ($urandom % 5 == 0);
            end
            default: begin
                // hold bursts of 8 to 23 cycles
                fetchHit = 1'b1;
                irq      = 1'b0;
                if (holdLeft == 0 && $urandom % 8 == 0) begin
                    holdLeft = 8 + int'($urandom % 16);
                end
                issueHold = (holdLeft != 0);
                if (holdLeft != 0) begin
                    holdLeft--;
                end
            end
        endcase
    end

    initial begin
        int cycles;
        void'($urandom(38));
        clk         = 1'b0;
        rst         = 1'b1;
        fetchWord   = '0;
        fetchHit    = 1'b1;
        irq         = 1'b0;
        fetchEnable = 1'b0;
        issueHold   = 1'b0;
        runEnable   = 1'b0;
        mode        = MODE_CLEAN;
        holdLeft    = 0;
        retireCount = 0;
        modelPc     = '0;
        buildProgram();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // idle with fetch disabled
        repeat (10) begin
            @(negedge clk);
            checkValue(32'(retire.valid), 32'd0, "retire.valid while idle");
            checkValue(32'(pipelineEmpty), 32'd1, "pipelineEmpty while idle");
            checkValue(32'(fetchAddr), 32'd0, "fetchAddr while idle");
        end

        runEnable = 1'b1;
        waitRetires(120, 2000, "clean");
        mode = MODE_RANDOM;
        waitRetires(260, 4000, "random");
        mode = MODE_HOLDS;
        waitRetires(400, 6000, "hold");

        // in-flight ops still retire in order while draining
        mode      = MODE_CLEAN;
        runEnable = 1'b0;
        sampleCycle();
        cycles = 0;
        while (!pipelineEmpty) begin
            if (cycles == 200) begin
                abortRun("pipeline did not become empty after fetch was disabled");
            end
            sampleCycle();
            cycles++;
        end

        repeat (20) begin
            @(negedge clk);
            checkValue(32'(retire.valid), 32'd0, "retire.valid after empty");
            checkValue(32'(pipelineEmpty), 32'd1, "pipelineEmpty after drain");
        end

        // every expected micro-op retired and fetch stopped at the next one
        checkValue(32'(expectQ.size()), 32'd0, "expected retires left over");
        checkValue(32'(fetchAddr), 32'(modelPc), "fetchAddr after drain");

        $display("retired %0d micro-ops", retireCount);
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- logic/PipelineCore.sv
/* pipeline control top */
`timescale 1ns/1ps

module PipelineCore (
    input  logic                     clk,
    input  logic                     rst,
    input  PipeCtrlTypes::OpWord     fetchWord,
    input  logic                     fetchHit,
    input  logic                     irq,
    input  logic                     fetchEnable,
    input  logic                     issueHold,
    output PipeCtrlTypes::PcAddr     fetchAddr,
    output PipeCtrlTypes::RetireInfo retire,
    output logic                     pipelineEmpty
);

    PipeCtrlTypes::PipelineControl npStage;
    PipeCtrlTypes::PipelineControl ifStage;
    PipeCtrlTypes::PipelineControl idStage;
    PipeCtrlTypes::PipelineControl rnStage;
    PipeCtrlTypes::PipelineControl isStage;
    PipeCtrlTypes::PipelineControl backEnd;

    PipeCtrlTypes::OpLatch fetchOut;
    PipeCtrlTypes::OpLatch decodeOut;
    PipeCtrlTypes::OpLatch renameOut;
    PipeCtrlTypes::PcAddr  redirectPc;

    logic ifSendBubble;
    logic npSendBubble;
    logic idStallUpper;
    logic rnSendBubble;
    logic cmFlushUpper;
    logic ifEmpty;
    logic idEmpty;
    logic rnEmpty;
    logic listEmpty;

    PipelineController ctrl_i (
        .rst, .ifSendBubble, .npSendBubble, .idStallUpper, .rnSendBubble,
        .cmFlushUpper, .issueHold, .ifEmpty, .idEmpty, .rnEmpty, .listEmpty,
        .npStage, .ifStage, .idStage, .rnStage, .isStage, .backEnd, .pipelineEmpty
    );

    FetchStage fetch_i (
        .clk, .rst, .npStage, .ifStage, .fetchWord, .redirect(cmFlushUpper),
        .redirectPc, .irq, .fetchEnable, .fetchHit, .fetchAddr, .fetchOut,
        .ifSendBubble, .npSendBubble, .ifEmpty
    );

    DecodeStage decode_i (
        .clk, .rst, .idStage, .fetchOut, .decodeOut, .idStallUpper, .idEmpty
    );

    RenameStage rename_i (
        .clk, .rst, .rnStage, .decodeOut, .retireValid(retire.valid),
        .flushed(cmFlushUpper), .renameOut, .rnSendBubble, .rnEmpty
    );

    CommitStage commit_i (
        .clk, .rst, .isStage, .backEnd, .renameOut, .retire, .cmFlushUpper,
        .redirectPc, .listEmpty
    );

endmodule

//--- logic/CommitStage.sv
/* issue latch, active list and commit */
`timescale 1ns/1ps

module CommitStage (
    input  logic                          clk,
    input  logic                          rst,
    input  PipeCtrlTypes::PipelineControl isStage,
    input  PipeCtrlTypes::PipelineControl backEnd,
    input  PipeCtrlTypes::OpLatch         renameOut,
    output PipeCtrlTypes::RetireInfo      retire,
    output logic                          cmFlushUpper,
    output PipeCtrlTypes::PcAddr          redirectPc,
    output logic                          listEmpty
);

    localparam int DEPTH = PipeCtrlTypes::ACTIVE_LIST_DEPTH;

    PipeCtrlTypes::OpLatch issueLatch;
    PipeCtrlTypes::OpLatch entries [DEPTH];
    logic [DEPTH-1:0]      listValid;
    PipeCtrlTypes::ListPtr head;
    PipeCtrlTypes::OpLatch headOp;
    logic                  retireNow;
    logic                  listWrite;

    assign headOp    = entries[head];
    assign retireNow = listValid[head] && !backEnd.stall;
    assign listWrite = issueLatch.valid && !isStage.stall;

    // retire port
    always_comb begin
        retire.valid    = retireNow;
        retire.pc       = headOp.pc;
        retire.kind     = headOp.word[PipeCtrlTypes::KIND_MSB:PipeCtrlTypes::KIND_LSB];
        retire.uopIndex = headOp.uopIndex;
    end

    // taken mispredicted branch at the head
    assign cmFlushUpper = retireNow && (retire.kind == PipeCtrlTypes::OP_BRANCH) &&
        headOp.word[PipeCtrlTypes::MISPREDICT_BIT];
    assign redirectPc = headOp.word[7:0];

    // issue latch
    always_ff @(posedge clk) begin
        if (isStage.clear || cmFlushUpper) begin
            issueLatch.valid <= 1'b0;
        end else if (!isStage.stall) begin
            issueLatch <= renameOut;
        end
    end

    // list payload
    always_ff @(posedge clk) begin
        if (listWrite) begin
            entries[issueLatch.tag] <= issueLatch;
        end
    end

    // valid bits
    always_ff @(posedge clk) begin
        if (backEnd.clear || cmFlushUpper) begin
            listValid <= '0;
        end else begin
            if (retireNow) begin
                listValid[head] <= 1'b0;
            end
            if (listWrite) begin
                listValid[issueLatch.tag] <= 1'b1;
            end
        end
    end

    // head pointer, realigned with rename after a flush
    always_ff @(posedge clk) begin
        if (rst || cmFlushUpper) begin
            head <= '0;
        end else if (retireNow) begin
            head <= head + PipeCtrlTypes::ListPtr'(1);
        end
    end

    assign listEmpty = !issueLatch.valid && (listValid == '0);

endmodule

//--- logic/RenameStage.sv
/* rename tagging and list occupancy */
`timescale 1ns/1ps

module RenameStage (
    input  logic                          clk,
    input  logic                          rst,
    input  PipeCtrlTypes::PipelineControl rnStage,
    input  PipeCtrlTypes::OpLatch         decodeOut,
    input  logic                          retireValid,
    input  logic                          flushed,
    output PipeCtrlTypes::OpLatch         renameOut,
    output logic                          rnSendBubble,
    output logic                          rnEmpty
);

    localparam int COUNT_W = $clog2(PipeCtrlTypes::ACTIVE_LIST_DEPTH + 1);

    logic [COUNT_W-1:0]    inFlight;
    PipeCtrlTypes::ListPtr nextTag;
    logic                  enter;

    // op accepted into the rename latch
    assign enter = decodeOut.valid && !rnStage.stall && !rnStage.clear;

    // one more op would overrun the list
    assign rnSendBubble = decodeOut.valid &&
        (32'(inFlight) + 32'd1 > PipeCtrlTypes::ACTIVE_LIST_DEPTH);

    // occupancy and tag pointer, both restart with the list on a flush
    always_ff @(posedge clk) begin
        if (rst || flushed) begin
            inFlight <= '0;
            nextTag  <= '0;
        end else begin
            if (enter) begin
                nextTag <= nextTag + PipeCtrlTypes::ListPtr'(1);
            end
            case ({enter, retireValid})
                2'b10:   inFlight <= inFlight + COUNT_W'(1);
                2'b01:   inFlight <= inFlight - COUNT_W'(1);
                default: inFlight <= inFlight;
            endcase
        end
    end

    // rename latch
    always_ff @(posedge clk) begin
        if (rnStage.clear) begin
            renameOut.valid <= 1'b0;
        end else if (!rnStage.stall) begin
            renameOut     <= decodeOut;
            renameOut.tag <= nextTag;
        end
    end

    assign rnEmpty = !renameOut.valid;

endmodule

//--- logic/DecodeStage.sv
/* decode and micro-op split */
`timescale 1ns/1ps

module DecodeStage (
    input  logic                          clk,
    input  logic                          rst,
    input  PipeCtrlTypes::PipelineControl idStage,
    input  PipeCtrlTypes::OpLatch         fetchOut,
    output PipeCtrlTypes::OpLatch         decodeOut,
    output logic                          idStallUpper,
    output logic                          idEmpty
);

    typedef enum logic {
        FirstUop,
        SecondUop
    } UopState;

    UopState state;
    UopState stateNext;
    logic    isDouble;
    PipeCtrlTypes::OpLatch decodeNext;

    assign isDouble = fetchOut.valid && (fetchOut.word[PipeCtrlTypes::KIND_MSB:
        PipeCtrlTypes::KIND_LSB] == PipeCtrlTypes::OP_DOUBLE);

    // uop 0 of a double keeps the word in the fetch latch
    assign idStallUpper = isDouble && (state == FirstUop);

    always_comb begin
        decodeNext = fetchOut;
        decodeNext.tag = '0;
        stateNext = FirstUop;
        if (isDouble) begin
            if (state == FirstUop) begin
                decodeNext.uopIndex = 1'b0;
                stateNext = SecondUop;
            end else begin
                decodeNext.uopIndex = 1'b1;
            end
        end else begin
            decodeNext.uopIndex = 1'b0;
        end
    end

    // split state
    always_ff @(posedge clk) begin
        if (rst || idStage.clear) begin
            state <= FirstUop;
        end else if (!idStage.stall) begin
            state <= stateNext;
        end
    end

    // decode latch
    always_ff @(posedge clk) begin
        if (idStage.clear) begin
            decodeOut.valid <= 1'b0;
        end else if (!idStage.stall) begin
            decodeOut <= decodeNext;
        end
    end

    assign idEmpty = !decodeOut.valid;

endmodule

//--- logic/FetchStage.sv
/* next-pc and fetch */
`timescale 1ns/1ps

module FetchStage (
    input  logic                          clk,
    input  logic                          rst,
    input  PipeCtrlTypes::PipelineControl npStage,
    input  PipeCtrlTypes::PipelineControl ifStage,
    input  PipeCtrlTypes::OpWord          fetchWord,
    input  logic                          redirect,
    input  PipeCtrlTypes::PcAddr          redirectPc,
    input  logic                          irq,
    input  logic                          fetchEnable,
    input  logic                          fetchHit,
    output PipeCtrlTypes::PcAddr          fetchAddr,
    output PipeCtrlTypes::OpLatch         fetchOut,
    output logic                          ifSendBubble,
    output logic                          npSendBubble,
    output logic                          ifEmpty
);

    PipeCtrlTypes::PcAddr  pc;
    PipeCtrlTypes::OpLatch fetchNext;

    // pc register
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!npStage.stall) begin
            pc <= pc + PipeCtrlTypes::PcAddr'(1);
        end
    end

    assign fetchAddr = pc;

    // word at the pc, tag is given later in rename
    always_comb begin
        fetchNext.valid    = fetchHit && !npStage.clear;
        fetchNext.pc       = pc;
        fetchNext.word     = fetchWord;
        fetchNext.uopIndex = 1'b0;
        fetchNext.tag      = '0;
    end

    // fetch latch
    always_ff @(posedge clk) begin
        if (ifStage.clear) begin
            fetchOut.valid <= 1'b0;
        end else if (!ifStage.stall) begin
            fetchOut <= fetchNext;
        end
    end

    // requests
    assign ifSendBubble = !fetchHit;
    assign npSendBubble = irq || !fetchEnable;
    assign ifEmpty      = !fetchOut.valid;

endmodule

//--- logic/PipelineController.sv
/* pipeline stall and clear control */
`timescale 1ns/1ps

module PipelineController (
    input  logic rst,
    input  logic ifSendBubble,
    input  logic npSendBubble,
    input  logic idStallUpper,
    input  logic rnSendBubble,
    input  logic cmFlushUpper,
    input  logic issueHold,
    input  logic ifEmpty,
    input  logic idEmpty,
    input  logic rnEmpty,
    input  logic listEmpty,
    output PipeCtrlTypes::PipelineControl npStage,
    output PipeCtrlTypes::PipelineControl ifStage,
    output PipeCtrlTypes::PipelineControl idStage,
    output PipeCtrlTypes::PipelineControl rnStage,
    output PipeCtrlTypes::PipelineControl isStage,
    output PipeCtrlTypes::PipelineControl backEnd,
    output logic pipelineEmpty
);

    // front end, lower stages win
    always_comb begin
        npStage = '{stall: 1'b0, clear: 1'b0};
        ifStage = '{stall: 1'b0, clear: 1'b0};
        idStage = '{stall: 1'b0, clear: 1'b0};
        rnStage = '{stall: 1'b0, clear: 1'b0};

        if (rst) begin
            // write invalid latches everywhere
            npStage.clear = 1'b1;
            ifStage.clear = 1'b1;
            idStage.clear = 1'b1;
            rnStage.clear = 1'b1;
        end else if (cmFlushUpper) begin
            // squash everything not yet in the list, np takes the redirect
            ifStage.clear = 1'b1;
            idStage.clear = 1'b1;
            rnStage.clear = 1'b1;
        end else if (issueHold) begin
            // issue latch is full, keep the rename latch too
            npStage.stall = 1'b1;
            ifStage.stall = 1'b1;
            idStage.stall = 1'b1;
            rnStage.stall = 1'b1;
        end else if (rnSendBubble) begin
            // list would overflow, bubble downstream
            npStage.stall = 1'b1;
            ifStage.stall = 1'b1;
            idStage.stall = 1'b1;
            rnStage.stall = 1'b1;
            rnStage.clear = 1'b1;
        end else if (idStallUpper) begin
            // hold the double word while uop 0 goes out
            npStage.stall = 1'b1;
            ifStage.stall = 1'b1;
        end else if (ifSendBubble) begin
            // fetch miss, retry same pc
            npStage.stall = 1'b1;
            npStage.clear = 1'b1;
            ifStage.stall = 1'b1;
            ifStage.clear = 1'b1;
        end else if (npSendBubble) begin
            // interrupt or fetch disabled
            npStage.stall = 1'b1;
            npStage.clear = 1'b1;
        end
    end

    // back end, the list keeps retiring under a hold
    always_comb begin
        isStage = '{stall: 1'b0, clear: 1'b0};
        backEnd = '{stall: 1'b0, clear: 1'b0};
        if (rst) begin
            isStage.clear = 1'b1;
            backEnd.clear = 1'b1;
        end else begin
            isStage.stall = issueHold;
        end
    end

    // np fetches something unless cleared
    assign pipelineEmpty = npStage.clear && ifEmpty && idEmpty && rnEmpty && listEmpty;

endmodule

//--- logic/PipeCtrlTypes.sv
/* pipeline control types */
package PipeCtrlTypes;

    // instruction address and word
    typedef logic [7:0]  PcAddr;
    typedef logic [15:0] OpWord;

    // kind field, bits 15..14 of the word
    typedef logic [1:0] OpKind;

    localparam OpKind OP_NORMAL = 2'd0;
    localparam OpKind OP_DOUBLE = 2'd1;
    localparam OpKind OP_BRANCH = 2'd2;

    // word field positions
    localparam int KIND_MSB = 15;
    localparam int KIND_LSB = 14;
    localparam int MISPREDICT_BIT = 13;

    // active list capacity, shared by rename and commit
    localparam int ACTIVE_LIST_DEPTH = 4;

    typedef logic [1:0] ListPtr;

    // per-stage control, clear wins over stall
    typedef struct packed {
        logic stall;
        logic clear;
    } PipelineControl;

    // op travelling down the pipeline
    typedef struct packed {
        logic   valid;
        PcAddr  pc;
        OpWord  word;
        logic   uopIndex;
        ListPtr tag;
    } OpLatch;

    // one retired micro-op
    typedef struct packed {
        logic  valid;
        PcAddr pc;
        OpKind kind;
        logic  uopIndex;
    } RetireInfo;

endpackage
